// File: Bender.yml
package:
  name: issue_stage

export_include_dirs:
  - include

sources:
  - logic/issue_pkg.sv
  - logic/decode_class.sv
  - logic/issue_buffer.sv
  - logic/issue_config.sv
  - logic/issue_top.sv
  - target: test
    files:
      - testbench/issue_asserts.sv
      - testbench/issue_tb.sv

// File: include/issue_settings.svh
`ifndef ISSUE_SETTINGS_SVH
`define ISSUE_SETTINGS_SVH

// number of instruction entries in the issue buffer, a power of two.
`define ISSUE_DEPTH 16

// addi x0,x0,0 placed in issue slots that carry no instruction.
`define NOP_INSTR 32'h0000_0013

// word address bits decoded by the register block.
`define WB_ADDR_WIDTH 4

`endif

// File: logic/decode_class.sv
`timescale 1ns/1ns
`default_nettype none

module decode_class import issue_pkg::*; (
  input  logic [31:0]  instr,
  output decode_info_t info
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [4:0] funct5;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct5 = instr[31:27];

  always_comb begin
    info = '0;
    info.waddr = instr[11:7];
    info.raddr1 = instr[19:15];
    info.raddr2 = instr[24:20];
    info.raddr3 = instr[31:27]; // rs3 of the fused multiply-add forms.
    case (opcode)
      opcode_lui, opcode_auipc: begin
        info.basic = 1'b1;
        info.wren = 1'b1;
      end
      opcode_immediate: begin
        info.basic = 1'b1;
        info.wren = 1'b1;
        info.rden1 = 1'b1;
      end
      opcode_register: begin
        info.basic = 1'b1;
        info.wren = 1'b1;
        info.rden1 = 1'b1;
        info.rden2 = 1'b1;
      end
      opcode_jal: begin
        info.complex = 1'b1;
        info.wren = 1'b1;
      end
      opcode_jalr, opcode_load: begin
        info.complex = 1'b1;
        info.wren = 1'b1;
        info.rden1 = 1'b1;
      end
      opcode_branch, opcode_store: begin
        info.complex = 1'b1;
        info.rden1 = 1'b1;
        info.rden2 = 1'b1;
      end
      opcode_system: begin
        info.complex = 1'b1;
        if (funct3 != 3'd0 && funct3 != 3'd4) begin
          info.wren = 1'b1;
          info.rden1 = ~funct3[2]; // immediate csr forms read no register.
        end
      end
      opcode_fload: begin
        info.complex = 1'b1;
        info.rden1 = 1'b1;
        info.fwren = 1'b1;
      end
      opcode_fstore: begin
        info.complex = 1'b1;
        info.rden1 = 1'b1;
        info.frden1 = 1'b1;
      end
      opcode_fp: begin
        case (funct5)
          funct_fadd, funct_fsub, funct_fmul, funct_fdiv, funct_fsgnj, funct_fminmax: begin
            info.complex = 1'b1;
            info.fwren = 1'b1;
            info.frden1 = 1'b1;
            info.frden2 = 1'b1;
          end
          funct_fsqrt: begin
            info.complex = 1'b1;
            info.fwren = 1'b1;
            info.frden1 = 1'b1;
          end
          funct_fcomp: begin
            info.complex = 1'b1;
            info.wren = 1'b1;
            info.frden1 = 1'b1;
            info.frden2 = 1'b1;
          end
          funct_fmv_f2i, funct_fconv_f2i: begin
            info.complex = 1'b1;
            info.wren = 1'b1;
            info.frden1 = 1'b1;
          end
          funct_fmv_i2f, funct_fconv_i2f: begin
            info.complex = 1'b1;
            info.rden1 = 1'b1;
            info.fwren = 1'b1;
          end
          default: begin
          end
        endcase
      end
      opcode_fmadd, opcode_fmsub, opcode_fnmsub, opcode_fnmadd: begin
        info.complex = 1'b1;
        info.fwren = 1'b1;
        info.frden1 = 1'b1;
        info.frden2 = 1'b1;
        info.frden3 = 1'b1;
      end
      default: begin
      end
    endcase
    if (info.waddr == 5'd0) begin
      info.wren = 1'b0; // x0 never holds a result.
    end
  end

endmodule

`default_nettype wire

// File: logic/issue_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module issue_buffer import issue_pkg::*; (
  input  logic       clock,
  input  logic       reset,
  input  fetch_t     fetch,
  input  logic       stall,
  input  logic       dual_enable,
  input  logic       flush,
  output issue_t     issue,
  output logic       full,
  output occupancy_t occupancy
);

  `include "issue_settings.svh"

  localparam int ptr_width = $clog2(`ISSUE_DEPTH);

  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] instr;
  } entry_t;

  entry_t mem [`ISSUE_DEPTH];

  logic [ptr_width-1:0] wptr;
  logic [ptr_width-1:0] wptr_1;
  logic [ptr_width-1:0] rptr;
  logic [ptr_width-1:0] rptr_1;
  occupancy_t           count;
  occupancy_t           avail;
  logic [1:0]           fetch_add;

  entry_t       fetch_lo;
  entry_t       fetch_hi;
  entry_t       head0;
  entry_t       head1;
  logic         valid0;
  logic         valid1;
  decode_info_t info0;
  decode_info_t info1;
  logic         int_hazard;
  logic         float_hazard;
  logic         pair_ok;
  logic [1:0]   pass;

  assign wptr_1 = wptr + ptr_width'(1);
  assign rptr_1 = rptr + ptr_width'(1);
  assign fetch_add = fetch.valid ? 2'd2 : 2'd0;
  assign avail = count + occupancy_t'(fetch_add);

  assign fetch_lo = '{pc: fetch.pc, instr: fetch.data[31:0]};
  assign fetch_hi = '{pc: fetch.pc + 32'd4, instr: fetch.data[63:32]};

  // an empty or nearly empty buffer is bypassed by the pair arriving this cycle.
  always_comb begin
    if (count == '0) begin
      head0 = fetch_lo;
      head1 = fetch_hi;
    end else if (count == occupancy_t'(1)) begin
      head0 = mem[rptr];
      head1 = fetch_lo;
    end else begin
      head0 = mem[rptr];
      head1 = mem[rptr_1];
    end
  end

  assign valid0 = avail != '0;
  assign valid1 = avail > occupancy_t'(1);

  decode_class u_decode0 (
    .instr (valid0 ? head0.instr : `NOP_INSTR),
    .info  (info0)
  );

  decode_class u_decode1 (
    .instr (valid1 ? head1.instr : `NOP_INSTR),
    .info  (info1)
  );

  assign int_hazard = info0.wren &
                      ((info1.rden1 && info1.raddr1 == info0.waddr) |
                       (info1.rden2 && info1.raddr2 == info0.waddr));
  assign float_hazard = info0.fwren &
                        ((info1.frden1 && info1.raddr1 == info0.waddr) |
                         (info1.frden2 && info1.raddr2 == info0.waddr) |
                         (info1.frden3 && info1.raddr3 == info0.waddr));
  assign pair_ok = (info0.basic | info0.complex) & info1.basic & ~int_hazard & ~float_hazard;

  always_comb begin
    if (stall || !valid0 || !(info0.basic || info0.complex)) begin
      pass = 2'd0;
    end else if (valid1 && pair_ok && dual_enable) begin
      pass = 2'd2;
    end else begin
      pass = 2'd1;
    end
  end

  always_comb begin
    issue.count = pass;
    issue.pc0 = (pass != 2'd0) ? head0.pc : 32'd0;
    issue.instr0 = (pass != 2'd0) ? head0.instr : `NOP_INSTR;
    issue.pc1 = (pass == 2'd2) ? head1.pc : 32'd0;
    issue.instr1 = (pass == 2'd2) ? head1.instr : `NOP_INSTR;
  end

  assign full = count > occupancy_t'(`ISSUE_DEPTH / 2);
  assign occupancy = count;

  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      wptr <= '0;
      rptr <= '0;
      count <= '0;
    end else if (flush) begin
      wptr <= '0; // a flush drops any pair fetched in the same cycle.
      rptr <= '0;
      count <= '0;
    end else begin
      wptr <= wptr + ptr_width'(fetch_add);
      rptr <= rptr + ptr_width'(pass);
      count <= avail - occupancy_t'(pass);
    end
  end

  always_ff @(posedge clock) begin
    if (fetch.valid && !flush) begin
      mem[wptr] <= fetch_lo;
      mem[wptr_1] <= fetch_hi;
    end
  end

endmodule

`default_nettype wire

// File: logic/issue_config.sv
`timescale 1ns/1ns
`default_nettype none

module issue_config import issue_pkg::*; (
  input  logic       clock,
  input  logic       reset,
  input  wb_req_t    wb_req,
  output wb_rsp_t    wb_rsp,
  input  occupancy_t occupancy,
  input  logic [1:0] issued,
  output logic       dual_enable,
  output logic       flush
);

  `include "issue_settings.svh"

  localparam logic [`WB_ADDR_WIDTH-1:0] addr_control = 'd0;
  localparam logic [`WB_ADDR_WIDTH-1:0] addr_occupancy = 'd1;
  localparam logic [`WB_ADDR_WIDTH-1:0] addr_issued = 'd2;

  logic        access;
  logic        write;
  logic        ack;
  logic [31:0] dat_r;
  logic [31:0] read_value;
  logic [31:0] issued_count;

  // the guard on ack keeps a held request from acking twice.
  assign access = wb_req.cyc & wb_req.stb & ~ack;
  assign write = access & wb_req.we;

  always_comb begin
    case (wb_req.adr)
      addr_control: read_value = {31'd0, dual_enable}; // flush bit reads zero.
      addr_occupancy: read_value = 32'(occupancy);
      addr_issued: read_value = issued_count;
      default: read_value = 32'd0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      ack <= 1'b0;
      flush <= 1'b0;
      dual_enable <= 1'b1;
      issued_count <= 32'd0;
    end else begin
      ack <= access;
      flush <= write && wb_req.adr == addr_control && wb_req.dat_w[1];
      if (write && wb_req.adr == addr_control) begin
        dual_enable <= wb_req.dat_w[0];
      end
      if (write && wb_req.adr == addr_issued) begin
        issued_count <= 32'd0;
      end else begin
        issued_count <= issued_count + 32'(issued);
      end
    end
  end

  always_ff @(posedge clock) begin
    if (access) begin
      dat_r <= read_value;
    end
  end

  assign wb_rsp.dat_r = dat_r;
  assign wb_rsp.ack = ack;

endmodule

`default_nettype wire

// File: logic/issue_pkg.sv
`default_nettype none

package issue_pkg;

  `include "issue_settings.svh"

  typedef logic [$clog2(`ISSUE_DEPTH):0] occupancy_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    logic [63:0] data; // lower instruction in bits 31:0.
  } fetch_t;

  typedef struct packed {
    logic [1:0]  count;
    logic [31:0] pc0;
    logic [31:0] instr0;
    logic [31:0] pc1;
    logic [31:0] instr1;
  } issue_t;

  typedef struct packed {
    logic       basic;
    logic       complex;
    logic       wren;
    logic       rden1;
    logic       rden2;
    logic       fwren;
    logic       frden1;
    logic       frden2;
    logic       frden3;
    logic [4:0] waddr;
    logic [4:0] raddr1;
    logic [4:0] raddr2;
    logic [4:0] raddr3;
  } decode_info_t;

  typedef struct packed {
    logic                      cyc;
    logic                      stb;
    logic                      we;
    logic [`WB_ADDR_WIDTH-1:0] adr;
    logic [31:0]               dat_w;
  } wb_req_t;

  typedef struct packed {
    logic [31:0] dat_r;
    logic        ack;
  } wb_rsp_t;

  localparam logic [6:0] opcode_lui       = 7'b0110111;
  localparam logic [6:0] opcode_auipc     = 7'b0010111;
  localparam logic [6:0] opcode_jal       = 7'b1101111;
  localparam logic [6:0] opcode_jalr      = 7'b1100111;
  localparam logic [6:0] opcode_branch    = 7'b1100011;
  localparam logic [6:0] opcode_load      = 7'b0000011;
  localparam logic [6:0] opcode_store     = 7'b0100011;
  localparam logic [6:0] opcode_immediate = 7'b0010011;
  localparam logic [6:0] opcode_register  = 7'b0110011;
  localparam logic [6:0] opcode_system    = 7'b1110011;
  localparam logic [6:0] opcode_fload     = 7'b0000111;
  localparam logic [6:0] opcode_fstore    = 7'b0100111;
  localparam logic [6:0] opcode_fp        = 7'b1010011;
  localparam logic [6:0] opcode_fmadd     = 7'b1000011;
  localparam logic [6:0] opcode_fmsub     = 7'b1000111;
  localparam logic [6:0] opcode_fnmsub    = 7'b1001011;
  localparam logic [6:0] opcode_fnmadd    = 7'b1001111;

  localparam logic [4:0] funct_fadd      = 5'b00000;
  localparam logic [4:0] funct_fsub      = 5'b00001;
  localparam logic [4:0] funct_fmul      = 5'b00010;
  localparam logic [4:0] funct_fdiv      = 5'b00011;
  localparam logic [4:0] funct_fsgnj     = 5'b00100;
  localparam logic [4:0] funct_fminmax   = 5'b00101;
  localparam logic [4:0] funct_fsqrt     = 5'b01011;
  localparam logic [4:0] funct_fcomp     = 5'b10100;
  localparam logic [4:0] funct_fconv_f2i = 5'b11000;
  localparam logic [4:0] funct_fconv_i2f = 5'b11010;
  localparam logic [4:0] funct_fmv_f2i   = 5'b11100; // shared with fclass.
  localparam logic [4:0] funct_fmv_i2f   = 5'b11110;

endpackage

`default_nettype wire

// File: logic/issue_top.sv
`timescale 1ns/1ns
`default_nettype none

module issue_top import issue_pkg::*; (
  input  logic    clock,
  input  logic    reset,
  input  fetch_t  fetch,
  input  logic    stall,
  output issue_t  issue,
  output logic    full,
  input  wb_req_t wb_req,
  output wb_rsp_t wb_rsp
);

  occupancy_t occupancy;
  logic       dual_enable;
  logic       flush;

  issue_buffer u_buffer (
    .clock       (clock),
    .reset       (reset),
    .fetch       (fetch),
    .stall       (stall),
    .dual_enable (dual_enable),
    .flush       (flush),
    .issue       (issue),
    .full        (full),
    .occupancy   (occupancy)
  );

  issue_config u_config (
    .clock       (clock),
    .reset       (reset),
    .wb_req      (wb_req),
    .wb_rsp      (wb_rsp),
    .occupancy   (occupancy),
    .issued      (issue.count), // stalled cycles add zero.
    .dual_enable (dual_enable),
    .flush       (flush)
  );

endmodule

`default_nettype wire

// File: testbench/issue_asserts.sv
`timescale 1ns/1ns
`default_nettype none

module issue_asserts import issue_pkg::*; (
  input logic       clock,
  input logic       reset,
  input fetch_t     fetch,
  input logic       stall,
  input logic       full,
  input issue_t     issue,
  input occupancy_t occupancy,
  input logic       dual_enable,
  input wb_req_t    wb_req,
  input wb_rsp_t    wb_rsp
);

  `include "issue_settings.svh"

  int fail_count = 0; // read by the testbench for its closing report.

  task automatic note_failure(input string what);
    $error("%s", what);
    fail_count++;
  endtask

  function automatic logic writes_int(logic [31:0] instr);
    case (instr[6:0])
      opcode_lui, opcode_auipc, opcode_immediate, opcode_register: return 1'b1;
      opcode_jal, opcode_jalr, opcode_load: return 1'b1;
      opcode_system: return instr[14:12] != 3'd0 && instr[14:12] != 3'd4;
      opcode_fp: return instr[31:27] inside {funct_fcomp, funct_fconv_f2i, funct_fmv_f2i};
      default: return 1'b0;
    endcase
  endfunction

  // the second slot must be basic, and basic instructions read only integer registers.
  function automatic logic pair_legal(logic [31:0] first, logic [31:0] second);
    logic [4:0] rd;
    logic       reads1;
    logic       reads2;
    rd = first[11:7];
    reads1 = second[6:0] inside {opcode_immediate, opcode_register};
    reads2 = second[6:0] == opcode_register;
    return second[6:0] inside {opcode_lui, opcode_auipc, opcode_immediate, opcode_register} &&
           !(rd != 5'd0 && writes_int(first) &&
             ((reads1 && second[19:15] == rd) || (reads2 && second[24:20] == rd)));
  endfunction

  a_order: assert property (@(posedge clock) disable iff (reset == 1'b0)
    issue.count != 2'd3 && (issue.count != 2'd2 || issue.pc1 == issue.pc0 + 32'd4))
    else note_failure("slot 1 issued without a matching slot 0 issue");

  a_pair: assert property (@(posedge clock) disable iff (reset == 1'b0)
    issue.count == 2'd2 |-> dual_enable && pair_legal(issue.instr0, issue.instr1))
    else note_failure("two instructions issued together against the pairing rule");

  a_stall: assert property (@(posedge clock) disable iff (reset == 1'b0)
    stall |-> issue.count == 2'd0)
    else note_failure("instructions issued while stall was high");

  a_full: assert property (@(posedge clock) disable iff (reset == 1'b0)
    full |-> !fetch.valid)
    else note_failure("fetch valid presented while the buffer was full");

  a_depth: assert property (@(posedge clock) disable iff (reset == 1'b0)
    occupancy <= occupancy_t'(`ISSUE_DEPTH))
    else note_failure("buffer occupancy went beyond its depth");

  a_ack: assert property (@(posedge clock) disable iff (reset == 1'b0)
    wb_req.cyc && wb_req.stb && !wb_rsp.ack |=> wb_rsp.ack ##1 !wb_rsp.ack)
    else note_failure("wishbone ack was not a single pulse one cycle after the request");

endmodule

bind issue_top issue_asserts checks (.*);

`default_nettype wire

// File: testbench/issue_tb.sv
`timescale 1ns/1ns
`default_nettype none

module issue_tb import issue_pkg::*; ();

  `include "issue_settings.svh"

  localparam int period = 40;
  localparam int random_pairs = 200;
  localparam int single_pairs = 50;
  localparam int watchdog_cycles = 10 * (random_pairs + single_pairs) + 500;

  logic        clock;
  logic        reset;
  logic        stall;
  logic        full;
  logic        hold_stall;
  fetch_t      fetch;
  issue_t      issue;
  wb_req_t     wb_req;
  wb_rsp_t     wb_rsp;
  logic [63:0] expected [$]; // pc and instruction in fetch order.
  logic [31:0] next_pc;
  logic [31:0] rdata;
  int          seed;
  int          errors;
  int          issued_seen;

  issue_top dut (.*);

  always #(period / 2) clock = ~clock;

  function automatic logic [31:0] build_instr(input int kind, input logic [4:0] rd,
                                              input logic [4:0] rs1, input logic [4:0] rs2);
    case (kind)
      0: return {12'd1, rs1, 3'b000, rd, opcode_immediate};
      1: return {7'd0, rs2, rs1, 3'b000, rd, opcode_register};
      2: return {20'h12345, rd, opcode_lui};
      3: return {12'd8, rs1, 3'b010, rd, opcode_load};
      4: return {7'd0, rs2, rs1, 3'b010, 5'd8, opcode_store};
      5: return {funct_fadd, 2'b00, rs2, rs1, 3'b000, rd, opcode_fp};
      6: return {rs2, 2'b00, rs2, rs1, 3'b000, rd, opcode_fmadd};
      default: return {7'd0, rs2, rs1, 3'b000, 5'd0, opcode_branch};
    endcase
  endfunction

  // small register range so that dependencies come up often.
  function automatic logic [31:0] random_instr();
    return build_instr($random(seed) & 7, 5'($random(seed) & 7), 5'($random(seed) & 7),
                       5'($random(seed) & 7));
  endfunction

  task automatic check_full();
    assert (full == (expected.size() > `ISSUE_DEPTH / 2)) else begin
      errors++;
      $display("ERROR %0t: full is %b with %0d entries held", $time, full, expected.size());
    end
  endtask

  task automatic fetch_pair(input logic [31:0] lo, input logic [31:0] hi);
    fetch.valid = 1'b0;
    stall = hold_stall;
    check_full();
    while (full) begin
      @(negedge clock);
    end
    stall = hold_stall | (($random(seed) & 3) == 0);
    fetch = '{valid: 1'b1, pc: next_pc, data: {hi, lo}};
    expected.push_back({next_pc, lo});
    expected.push_back({next_pc + 32'd4, hi});
    next_pc = next_pc + 32'd8;
    @(negedge clock);
    fetch.valid = 1'b0;
  endtask

  task automatic drain();
    stall = 1'b0;
    while (expected.size() != 0) begin
      @(negedge clock);
    end
  endtask

  task automatic wb_access(input logic we, input logic [`WB_ADDR_WIDTH-1:0] adr,
                           input logic [31:0] wdata);
    wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat_w: wdata};
    do begin
      @(negedge clock);
    end while (!wb_rsp.ack);
    rdata = wb_rsp.dat_r;
    wb_req = '0;
  endtask

  task automatic check_equal(input logic [31:0] got, input logic [31:0] want, input string what);
    assert (got == want) else begin
      errors++;
      $display("ERROR %0t: %s read %h, expected %h", $time, what, got, want);
    end
  endtask

  task automatic check_slot(input logic [31:0] pc, input logic [31:0] instr);
    logic [63:0] head;
    assert (expected.size() != 0) else begin
      errors++;
      $display("ERROR %0t: pc %h issued with nothing left to issue", $time, pc);
    end
    if (expected.size() != 0) begin
      head = expected.pop_front();
      assert (head == {pc, instr}) else begin
        errors++;
        $display("ERROR %0t: issued pc %h instr %h, expected pc %h instr %h",
                 $time, pc, instr, head[63:32], head[31:0]);
      end
    end
  endtask

  task automatic check_empty(input logic [31:0] pc, input logic [31:0] instr, input int slot);
    assert (pc == 32'd0 && instr == `NOP_INSTR) else begin
      errors++;
      $display("ERROR %0t: empty slot %0d carries pc %h instr %h", $time, slot, pc, instr);
    end
  endtask

  always @(posedge clock) begin
    if (reset == 1'b1) begin
      if (issue.count == 2'd0) begin
        check_empty(issue.pc0, issue.instr0, 0);
      end else begin
        check_slot(issue.pc0, issue.instr0);
      end
      if (issue.count == 2'd2) begin
        check_slot(issue.pc1, issue.instr1);
      end else begin
        check_empty(issue.pc1, issue.instr1, 1);
      end
      issued_seen = issued_seen + issue.count;
    end
  end

  initial begin
    seed = 32'h7d8f_7d3f;
    clock = 1'b0;
    reset = 1'b0;
    stall = 1'b0;
    hold_stall = 1'b0;
    fetch = '0;
    wb_req = '0;
    next_pc = 32'h0000_1000;
    errors = 0;
    issued_seen = 0;
    repeat (3) begin
      @(negedge clock);
    end
    reset = 1'b1;
    fetch_pair(build_instr(0, 5, 1, 0), build_instr(1, 6, 5, 2)); // dependent add issues alone.
    fetch_pair(build_instr(0, 5, 1, 0), build_instr(0, 7, 1, 0));
    fetch_pair(build_instr(3, 8, 2, 0), build_instr(0, 9, 8, 0)); // load result used next.
    fetch_pair(build_instr(5, 3, 1, 2), build_instr(1, 3, 3, 3)); // f3 and x3 are different files.
    repeat (random_pairs) begin
      fetch_pair(random_instr(), random_instr());
    end
    drain();
    wb_access(1'b0, 2, 32'd0);
    check_equal(rdata, issued_seen, "issued count");
    wb_access(1'b1, 2, 32'd0);
    issued_seen = 0;
    wb_access(1'b1, 0, 32'd0);
    wb_access(1'b0, 0, 32'd0);
    check_equal(rdata, 32'd0, "control");
    repeat (single_pairs) begin
      fetch_pair(random_instr(), random_instr());
    end
    drain();
    wb_access(1'b1, 0, 32'd1);
    hold_stall = 1'b1;
    fetch_pair(random_instr(), random_instr());
    fetch_pair(random_instr(), random_instr());
    wb_access(1'b1, 0, 32'd3);
    @(negedge clock);
    expected.delete(); // the flushed pairs never issue.
    wb_access(1'b0, 1, 32'd0);
    check_equal(rdata, 32'd0, "occupancy after flush");
    wb_access(1'b0, 0, 32'd0);
    check_equal(rdata, 32'd1, "control");
    wb_access(1'b0, 5, 32'd0);
    check_equal(rdata, 32'd0, "unmapped address");
    hold_stall = 1'b0;
    fetch_pair(build_instr(2, 4, 0, 0), build_instr(0, 4, 4, 0));
    drain();
    wb_access(1'b0, 2, 32'd0);
    check_equal(rdata, issued_seen, "issued count");
    $display("errors: %0d in order and register checks, %0d in bound assertions",
             errors, dut.checks.fail_count);
    if (errors == 0 && dut.checks.fail_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    #(watchdog_cycles * period);
    $display("watchdog expired before the tests finished");
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+include
logic/issue_pkg.sv
logic/decode_class.sv
logic/issue_buffer.sv
logic/issue_config.sv
logic/issue_top.sv
testbench/issue_asserts.sv
testbench/issue_tb.sv
